// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -f src.f
	./obj_dir/VcpuTb +verilator+error+limit+100 | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Power-on reset for five rising edges, released just after the edge
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
    end

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpu_pkg::*; ();

    localparam int NumTests = 5;
    localparam int MaxWords = 16;
    localparam int HaltTimeout = 200;

    logic   clk;
    logic   porRstN;
    logic   testRstN;
    logic   rstN;
    logic   systemEn = 1'b0;
    logic   pauseMode;
    logic   collecting;
    dataT   instrAddr;
    dataT   instrData;
    retireT retire;
    logic   halted;

    // One row of the test table per program
    string       names     [NumTests];
    dataT        programs  [NumTests][MaxWords];
    logic [19:0] expRetire [NumTests][MaxWords];
    int          expCount  [NumTests];
    dataT        expPc     [NumTests];
    int          rowCount;
    int          wordCount;

    dataT        rom [MaxWords];
    logic [19:0] seen [$];
    int          errCount;
    int          passCount;
    int          failCount;

    assign rstN = porRstN && testRstN;

    clockGen clocks (
        .clk  (clk),
        .rstN (porRstN)
    );

    cpuTop DUT (
        .clk       (clk),
        .rstN      (rstN),
        .systemEn  (systemEn),
        .instrData (instrData),
        .instrAddr (instrAddr),
        .retire    (retire),
        .halted    (halted)
    );

    // Past the program the ROM returns NOPs tagged with the full address
    assign instrData = (instrAddr[15:4] == '0) ? rom[instrAddr[3:0]] :
        {4'hC, instrAddr[11:0] ^ {8'h00, instrAddr[15:12]}};

    // systemEn changes 2 ns after each rising edge
    always @(posedge clk) begin
        #2;
        if (pauseMode) begin
            systemEn = (($urandom % 4) != 0);
        end else begin
            systemEn = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (collecting && retire.wbValid === 1'b1) begin
            seen.push_back({retire.addr, retire.data});
        end
    end

    // Field is the low byte, rB sits in its high nibble
    function automatic dataT encode(opcodeT op, int ra, int field);
        return {op, ra[3:0], field[7:0]};
    endfunction

    task automatic newTest(string name, dataT finalPc);
        rowCount++;
        names[rowCount] = name;
        expPc[rowCount] = finalPc;
        expCount[rowCount] = 0;
        wordCount = 0;
        for (int i = 0; i < MaxWords; i++) begin
            programs[rowCount][i] = encode(NOP, 0, i);
        end
    endtask

    task automatic emit(opcodeT op, int ra, int field);
        programs[rowCount][wordCount] = encode(op, ra, field);
        wordCount++;
    endtask

    task automatic expectWb(int addr, dataT data);
        expRetire[rowCount][expCount[rowCount]] = {addr[3:0], data};
        expCount[rowCount]++;
    endtask

    task automatic buildTable();
        // Final PC is the HALT address plus three
        newTest("alu", 16'h000D);
        emit(LI, 1, 'h5A);
        emit(LI, 2, 'h0F);
        emit(LI, 3, 'h03);
        emit(ADD, 1, 'h20);
        emit(SHL, 1, 'h30);
        emit(SHR, 1, 'h30);
        emit(XOR, 1, 'h20);
        emit(OR, 2, 'h10);
        emit(SUB, 3, 'h10);
        emit(AND, 3, 'h20);
        emit(HALT, 0, 0);
        expectWb(1, 16'h005A);
        expectWb(2, 16'h000F);
        expectWb(3, 16'h0003);
        expectWb(1, 16'h0069);
        expectWb(1, 16'h0348);
        expectWb(1, 16'h0069);
        expectWb(1, 16'h0066);
        expectWb(2, 16'h006F);
        expectWb(3, 16'hFF9D);
        expectWb(3, 16'h000D);

        newTest("immediates", 16'h000A);
        emit(LI, 5, 'h34);
        emit(LUI, 5, 'h12);
        emit(ADDI, 5, 'hFF);
        emit(ADDI, 5, 'h80);
        emit(LI, 6, 'hFE);
        emit(LUI, 6, 'hAB);
        emit(ADDI, 7, 'h85);
        emit(HALT, 0, 0);
        expectWb(5, 16'h0034);
        expectWb(5, 16'h1234);
        expectWb(5, 16'h1233);
        expectWb(5, 16'h11B3);
        expectWb(6, 16'h00FE);
        expectWb(6, 16'hABFE);
        expectWb(7, 16'hFF85);

        // Producers one and two slots ahead
        newTest("forwarding", 16'h000A);
        emit(LI, 1, 'h11);
        emit(LI, 2, 'h22);
        emit(ADD, 1, 'h20);
        emit(ADD, 2, 'h10);
        emit(LI, 3, 'h07);
        emit(SUB, 2, 'h10);
        emit(ADD, 3, 'h20);
        emit(HALT, 0, 0);
        expectWb(1, 16'h0011);
        expectWb(2, 16'h0022);
        expectWb(1, 16'h0033);
        expectWb(2, 16'h0055);
        expectWb(3, 16'h0007);
        expectWb(2, 16'h0022);
        expectWb(3, 16'h0029);

        // Any write to r3, r6 or r7 means a shadow slot retired
        newTest("branch", 16'h000C);
        emit(LI, 1, 'h01);
        emit(BEQZ, 1, 'h03);
        emit(LI, 2, 'h02);
        emit(BEQZ, 0, 'h07);
        for (int i = 4; i < 9; i++) begin
            emit(LI, 3, 'h33);
        end
        emit(HALT, 0, 0);
        emit(LI, 5, 'h55);
        emit(BEQZ, 0, 'hFE);
        emit(LI, 6, 'h66);
        emit(LI, 7, 'h77);
        expectWb(1, 16'h0001);
        expectWb(2, 16'h0002);
        expectWb(5, 16'h0055);

        newTest("halt", 16'h0004);
        emit(LI, 1, 'h01);
        emit(HALT, 0, 0);
        emit(LI, 2, 'h02);
        emit(LI, 3, 'h03);
        expectWb(1, 16'h0001);
    endtask

    task automatic runPass(int row, bit paused, string label);
        int cycles;
        bit stopped;
        pauseMode = paused;
        collecting = 1'b0;
        @(posedge clk);
        #2;
        testRstN = 1'b0;
        for (int i = 0; i < MaxWords; i++) begin
            rom[i] = programs[row][i];
        end
        repeat (5) @(posedge clk);
        #2;
        testRstN = 1'b1;
        seen.delete();
        collecting = 1'b1;

        cycles = 0;
        while (halted !== 1'b1 && cycles < HaltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        stopped = (halted === 1'b1);
        assert (stopped) else begin
            $display("%s: core did not halt within %0d cycles", label, HaltTimeout);
            errCount++;
        end

        // Quiet window after the stop
        repeat (4) @(negedge clk);
        collecting = 1'b0;
        if (stopped) begin
            assert (halted === 1'b1) else begin
                $display("%s: halted did not stay high", label);
                errCount++;
            end
        end

        assert (seen.size() == expCount[row]) else begin
            $display("Error %s: retire count expected %0d actual %0d",
                     label, expCount[row], seen.size());
            errCount++;
        end
        for (int i = 0; i < expCount[row] && i < seen.size(); i++) begin
            assert (seen[i] === expRetire[row][i]) else begin
                $display("Error %s: retire %0d expected r%0d=%h actual r%0d=%h", label, i,
                         expRetire[row][i][19:16], expRetire[row][i][15:0],
                         seen[i][19:16], seen[i][15:0]);
                errCount++;
            end
        end
        // Pauses shift the last PC steps, so only the steady run checks it
        if (!paused) begin
            assert (instrAddr === expPc[row]) else begin
                $display("Error %s: final PC expected %h actual %h",
                         label, expPc[row], instrAddr);
                errCount++;
            end
        end
    endtask

    initial begin
        int waitCycles;
        int errBefore;
        void'($urandom(32'h72f7_942b));
        testRstN = 1'b0;
        pauseMode = 1'b0;
        collecting = 1'b0;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        rowCount = -1;
        for (int i = 0; i < MaxWords; i++) begin
            rom[i] = encode(NOP, 0, i);
        end
        buildTable();

        waitCycles = 0;
        while (porRstN !== 1'b1 && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        assert (porRstN === 1'b1) else begin
            $display("Power-on reset was never released");
            errCount++;
        end

        for (int t = 0; t <= rowCount; t++) begin
            errBefore = errCount;
            runPass(t, 1'b0, {names[t], "/steady"});
            runPass(t, 1'b1, {names[t], "/paused"});
            if (errCount == errBefore) begin
                passCount++;
                $display("Test %s: pass", names[t]);
            end else begin
                failCount++;
                $display("Test %s: FAIL", names[t]);
            end
        end

        $display("Tests passed: %0d, failed: %0d, property failures: %0d",
                 passCount, failCount, DUT.props.failures);
        if (errCount == 0 && DUT.props.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: bench/cpu_props.sv
`timescale 1ns/1ps

module cpuProps import cpu_pkg::*; (
    input logic   clk,
    input logic   rstN,
    input logic   halted,
    input logic   branchTaken,
    input retireT retire
);

    int unsigned haltFails = 0;
    int unsigned wbFails = 0;
    int unsigned flushFails = 0;
    int unsigned failures;

    assign failures = haltFails + wbFails + flushFails;

    // Only reset leaves the halted state
    haltHolds: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else begin
            haltFails++;
            $error("halted fell without a reset");
        end

    // Nothing retires once the core has stopped
    quietWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !retire.wbValid)
        else begin
            wbFails++;
            $error("writeback seen while halted");
        end

    // The two shadow slots of a taken branch never reach writeback
    takenFlushes: assert property (@(posedge clk) disable iff (!rstN)
        ($past(branchTaken, 2) || $past(branchTaken, 3)) |-> !retire.wbValid)
        else begin
            flushFails++;
            $error("instruction behind a taken branch retired");
        end

endmodule

bind cpuTop cpuProps props (
    .clk         (clk),
    .rstN        (rstN),
    .halted      (halted),
    .branchTaken (branchTaken),
    .retire      (retire)
);

// File: design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   systemEn,
    input  dataT   instrData,
    output dataT   instrAddr,
    output retireT retire,
    output logic   halted
);

    fetchBufT fetchBuf;
    decodedT  decoded;
    issueBufT issueBuf;
    retireT   wb;
    regAddrT  readAddrA;
    regAddrT  readAddrB;
    dataT     readDataA;
    dataT     readDataB;
    logic     fwdValid;
    regAddrT  fwdAddr;
    dataT     fwdData;
    logic     branchTaken;
    dataT     branchTarget;
    logic     haltSeen;
    logic     fetchEn;
    logic     flush;

    assign retire = wb;

    fetchStage fetch (
        .clk          (clk),
        .rstN         (rstN),
        .fetchEn      (fetchEn),
        .flush        (flush),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .instrData    (instrData),
        .instrAddr    (instrAddr),
        .fetchBuf     (fetchBuf)
    );

    instructionDecoder decoder (
        .fetchBuf (fetchBuf),
        .decoded  (decoded)
    );

    registerFile regFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .wb        (wb)
    );

    issueStage issue (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .fetchBuf  (fetchBuf),
        .decoded   (decoded),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .fwdValid  (fwdValid),
        .fwdAddr   (fwdAddr),
        .fwdData   (fwdData),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .issueBuf  (issueBuf)
    );

    executeUnit execute (
        .clk          (clk),
        .rstN         (rstN),
        .issueBuf     (issueBuf),
        .fwdValid     (fwdValid),
        .fwdAddr      (fwdAddr),
        .fwdData      (fwdData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .haltSeen     (haltSeen),
        .wb           (wb)
    );

    stallControl stallCtl (
        .clk         (clk),
        .rstN        (rstN),
        .systemEn    (systemEn),
        .branchTaken (branchTaken),
        .haltSeen    (haltSeen),
        .fetchEn     (fetchEn),
        .flush       (flush),
        .halted      (halted)
    );

endmodule

// File: design/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] dataT;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddrT;

    // Opcode field, codes 13 to 15 decode as NOP
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SHL  = 4'h5,
        SHR  = 4'h6,
        LI   = 4'h7,
        LUI  = 4'h8,
        ADDI = 4'h9,
        BEQZ = 4'hA,
        HALT = 4'hB,
        NOP  = 4'hC
    } opcodeT;

    typedef enum logic {
        RUN,
        HALTED
    } ctrlStateT;

    typedef struct packed {
        logic valid;
        dataT pc;
        dataT instr;
    } fetchBufT;

    typedef struct packed {
        opcodeT  opcode;
        regAddrT addrA;
        regAddrT addrB;
        logic    readEnA;
        logic    readEnB;
        logic    writeEn;
        logic    immEn;
        dataT    imm;
    } decodedT;

    typedef struct packed {
        logic    valid;
        opcodeT  opcode;
        logic    writeEn;
        regAddrT destAddr;
        dataT    operandA;
        dataT    operandB;
        dataT    pc;
    } issueBufT;

    // Writeback bus, also the retire port
    typedef struct packed {
        logic    wbValid;
        regAddrT addr;
        dataT    data;
    } retireT;

endpackage

// File: design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path width in bits
`define CPU_DATA_WIDTH 16

// General registers, addressed by a four-bit field
`define CPU_REG_COUNT 16

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

`endif

// File: design/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  issueBufT issueBuf,
    output logic     fwdValid,
    output regAddrT  fwdAddr,
    output dataT     fwdData,
    output logic     branchTaken,
    output dataT     branchTarget,
    output logic     haltSeen,
    output retireT   wb
);

    dataT a;
    dataT b;
    dataT result;

    assign a = issueBuf.operandA;
    assign b = issueBuf.operandB;

    always_comb begin
        case (issueBuf.opcode)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SHL:     result = a << b[3:0];
            SHR:     result = a >> b[3:0];
            // Issue already built the final value in B
            LI, LUI: result = b;
            ADDI:    result = a + b;
            default: result = '0;
        endcase
    end

    // Branch target is relative to the branch itself
    assign branchTaken  = issueBuf.valid && issueBuf.opcode == BEQZ && a == '0;
    assign branchTarget = issueBuf.pc + b;
    assign haltSeen     = issueBuf.valid && issueBuf.opcode == HALT;

    assign fwdValid = issueBuf.valid && issueBuf.writeEn;
    assign fwdAddr  = issueBuf.destAddr;
    assign fwdData  = result;

    always_ff @(posedge clk) begin
        wb.addr <= fwdAddr;
        wb.data <= fwdData;
        if (!rstN) begin
            wb.wbValid <= 1'b0;
        end else begin
            wb.wbValid <= fwdValid;
        end
    end

endmodule

// File: design/fetchStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetchStage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     fetchEn,
    input  logic     flush,
    input  logic     branchTaken,
    input  dataT     branchTarget,
    input  dataT     instrData,
    output dataT     instrAddr,
    output fetchBufT fetchBuf
);

    dataT pc;

    assign instrAddr = pc;

    // Redirect wins over the sequential step
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `CPU_RESET_PC;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (fetchEn) begin
            pc <= pc + 1'b1;
        end
    end

    // Bubble when fetch is paused or the pipe is flushed
    always_ff @(posedge clk) begin
        fetchBuf.pc    <= pc;
        fetchBuf.instr <= instrData;
        if (!rstN) begin
            fetchBuf.valid <= 1'b0;
        end else begin
            fetchBuf.valid <= fetchEn && !flush;
        end
    end

endmodule

// File: design/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder import cpu_pkg::*; (
    input  fetchBufT fetchBuf,
    output decodedT  decoded
);

    logic [3:0] opField;
    logic [7:0] imm8;

    assign opField = fetchBuf.instr[15:12];
    assign imm8    = fetchBuf.instr[7:0];

    always_comb begin
        decoded.opcode  = NOP;
        decoded.addrA   = fetchBuf.instr[11:8];
        decoded.addrB   = fetchBuf.instr[7:4];
        decoded.readEnA = 1'b0;
        decoded.readEnB = 1'b0;
        decoded.writeEn = 1'b0;
        decoded.immEn   = 1'b0;
        decoded.imm     = '0;

        // Unused codes and empty slots stay NOP
        if (fetchBuf.valid && opField <= NOP) begin
            decoded.opcode = opcodeT'(opField);
        end

        case (decoded.opcode)
            ADD, SUB, AND, OR, XOR, SHL, SHR: begin
                decoded.readEnA = 1'b1;
                decoded.readEnB = 1'b1;
                decoded.writeEn = 1'b1;
            end
            LI: begin
                decoded.writeEn = 1'b1;
                decoded.immEn   = 1'b1;
                decoded.imm     = {8'h00, imm8};
            end
            // Low byte comes from rA in issue
            LUI: begin
                decoded.readEnA = 1'b1;
                decoded.writeEn = 1'b1;
                decoded.immEn   = 1'b1;
                decoded.imm     = {imm8, 8'h00};
            end
            ADDI: begin
                decoded.readEnA = 1'b1;
                decoded.writeEn = 1'b1;
                decoded.immEn   = 1'b1;
                decoded.imm     = {{8{imm8[7]}}, imm8};
            end
            // Branch offset rides in operand B
            BEQZ: begin
                decoded.readEnA = 1'b1;
                decoded.immEn   = 1'b1;
                decoded.imm     = {{8{imm8[7]}}, imm8};
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/issueStage.sv
`timescale 1ns/1ps

module issueStage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     flush,
    input  fetchBufT fetchBuf,
    input  decodedT  decoded,
    input  dataT     readDataA,
    input  dataT     readDataB,
    input  logic     fwdValid,
    input  regAddrT  fwdAddr,
    input  dataT     fwdData,
    output regAddrT  readAddrA,
    output regAddrT  readAddrB,
    output issueBufT issueBuf
);

    dataT opA;
    dataT opB;
    dataT opBSel;

    assign readAddrA = decoded.addrA;
    assign readAddrB = decoded.addrB;

    // Producer one slot ahead is still in execute
    always_comb begin
        opA = readDataA;
        opB = readDataB;
        if (decoded.readEnA && fwdValid && fwdAddr == decoded.addrA) begin
            opA = fwdData;
        end
        if (decoded.readEnB && fwdValid && fwdAddr == decoded.addrB) begin
            opB = fwdData;
        end
    end

    // Immediate mux, LUI merges with the old low byte of rA
    always_comb begin
        opBSel = opB;
        if (decoded.immEn) begin
            if (decoded.opcode == LUI) begin
                opBSel = {decoded.imm[15:8], opA[7:0]};
            end else begin
                opBSel = decoded.imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        issueBuf.opcode   <= decoded.opcode;
        issueBuf.writeEn  <= decoded.writeEn;
        issueBuf.destAddr <= decoded.addrA;
        issueBuf.operandA <= opA;
        issueBuf.operandB <= opBSel;
        issueBuf.pc       <= fetchBuf.pc;
        if (!rstN) begin
            issueBuf.valid <= 1'b0;
        end else begin
            issueBuf.valid <= fetchBuf.valid && !flush;
        end
    end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module registerFile import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT readAddrA,
    input  regAddrT readAddrB,
    output dataT    readDataA,
    output dataT    readDataB,
    input  retireT  wb
);

    dataT regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wbValid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Write-through covers a producer two slots ahead
    assign readDataA = (wb.wbValid && wb.addr == readAddrA) ? wb.data : regs[readAddrA];
    assign readDataB = (wb.wbValid && wb.addr == readAddrB) ? wb.data : regs[readAddrB];

endmodule

// File: design/stallControl.sv
`timescale 1ns/1ps

module stallControl import cpu_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic systemEn,
    input  logic branchTaken,
    input  logic haltSeen,
    output logic fetchEn,
    output logic flush,
    output logic halted
);

    ctrlStateT state;
    ctrlStateT stateNext;

    always_comb begin
        stateNext = state;
        if (state == RUN && haltSeen) begin
            stateNext = HALTED;
        end
    end

    // Only reset leaves HALTED
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= RUN;
        end else begin
            state <= stateNext;
        end
    end

    assign fetchEn = (state == RUN) && systemEn;
    // Kills the two younger instructions
    assign flush   = branchTaken || haltSeen;
    assign halted  = (state == HALTED);

endmodule

// File: src.f
+incdir+design
design/cpu_pkg.sv
design/fetchStage.sv
design/instructionDecoder.sv
design/stallControl.sv
design/registerFile.sv
design/issueStage.sv
design/executeUnit.sv
design/cpuTop.sv
bench/clockGen.sv
bench/cpu_props.sv
bench/cpuTb.sv
